// File: filelist.f
src/sdrc_pkg.sv
src/sdrc_req_gen.sv
src/sdrc_bank_ctl.sv
src/sdrc_xfr_ctl.sv
src/sdrc_bs_convert.sv
src/sdrc_core.sv
verification/sdram_model.sv
verification/tb_sdrc_core.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -Wno-fatal --top-module tb_sdrc_core -f filelist.f -o tb_sdrc_core \
   && ./obj_dir/tb_sdrc_core | tee /dev/stderr | grep -q "No errors" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: src/sdrc_bank_ctl.sv
`timescale 1ns/100ps

module sdrc_bank_ctl import sdrc_pkg::*; #(
   parameter int TRCD = 2
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      r2b_req,
   input  bank_t     r2b_ba,
   input  row_t      r2b_row,
   input  col_t      r2b_col,
   input  logic      r2b_write,
   input  logic      x2b_ack,
   output logic      b2r_ack,
   output logic      b2x_req,
   output sdr_cmd_t  b2x_cmd,
   output bank_t     b2x_ba,
   output sdr_addr_t b2x_addr
);

   localparam int CNT_W = $clog2(TRCD + 1);

   logic             act_wait;  // ACT on the pins, tRCD running
   logic [CNT_W-1:0] trcd_cnt;
   logic             start;     // Open the bank for a new request
   logic             rw_go;     // tRCD over, offer the column command
   sdr_addr_t        rw_addr;

   assign start   = r2b_req && !b2x_req && !act_wait;
   assign rw_go   = act_wait && (trcd_cnt == '0);
   assign b2r_ack = x2b_ack && (b2x_cmd != CMD_ACT);  // READ/WRITE accepted

   // Column with auto precharge, closed page
   always_comb begin
      rw_addr         = '0;
      rw_addr[7:0]    = r2b_col;
      rw_addr[AP_BIT] = 1'b1;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         b2x_req  <= 1'b0;
         act_wait <= 1'b0;
         trcd_cnt <= '0;
      end else if (start) begin
         b2x_req <= 1'b1;
      end else if (x2b_ack) begin
         b2x_req  <= 1'b0;
         act_wait <= (b2x_cmd == CMD_ACT);
         trcd_cnt <= CNT_W'(TRCD - 1);
      end else if (rw_go) begin
         act_wait <= 1'b0;
         b2x_req  <= 1'b1;
      end else if (act_wait) begin
         trcd_cnt <= trcd_cnt - 1'b1;
      end
   end

   // Command payload towards the sequencer
   always_ff @(posedge clk) begin
      if (start) begin
         b2x_cmd  <= CMD_ACT;
         b2x_ba   <= r2b_ba;
         b2x_addr <= r2b_row;
      end else if (rw_go) begin
         b2x_cmd  <= r2b_write ? CMD_WRITE : CMD_READ;
         b2x_addr <= rw_addr;     // Bank stays from ACT
      end
   end

endmodule

// File: src/sdrc_bs_convert.sv
`timescale 1ns/100ps

module sdrc_bs_convert import sdrc_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  app_data_t app_wr_data,
   input  app_be_t   app_be,
   input  sdr_data_t sdr_din,
   input  logic      x2c_wr_hi,
   input  logic      x2c_rd_lo,
   input  logic      x2c_rd_hi,
   output sdr_data_t sdr_dout,
   output sdr_mask_t sdr_dqm,
   output app_data_t app_rd_data
);

   sdr_data_t din_q;   // Input capture stage

   // Write split, low half first
   assign sdr_dout = x2c_wr_hi ? app_wr_data[31:16] : app_wr_data[15:0];
   assign sdr_dqm  = x2c_wr_hi ? ~app_be[3:2] : ~app_be[1:0];  // Mask is inverted enable

   always_ff @(posedge clk) begin
      din_q <= sdr_din;
   end

   // Read word packing
   always_ff @(posedge clk) begin
      if (rst) begin
         app_rd_data <= '0;
      end else begin
         if (x2c_rd_lo) begin
            app_rd_data[15:0] <= din_q;
         end
         if (x2c_rd_hi) begin
            app_rd_data[31:16] <= din_q;   // Held until the next read
         end
      end
   end

endmodule

// File: src/sdrc_core.sv
`timescale 1ns/100ps

module sdrc_core import sdrc_pkg::*; #(
   parameter int CAS_LAT       = 2,
   parameter int TRCD          = 2,
   parameter int TRP           = 2,
   parameter int TRFC          = 6,
   parameter int TWR           = 2,
   parameter int RFSH_INTERVAL = 1560,   // 15.6 us at 100 MHz
   parameter int INIT_WAIT     = 20000   // 200 us power-up wait
) (
   input  logic      clk,
   input  logic      rst,
   // Application port, four-phase
   input  logic      app_req,
   input  app_addr_t app_addr,
   input  logic      app_wr_n,
   input  app_data_t app_wr_data,
   input  app_be_t   app_be,
   output logic      app_req_ack,
   output app_data_t app_rd_data,
   output logic      sdr_init_done,
   // SDRAM pins
   output logic      sdr_cs_n,
   output logic      sdr_ras_n,
   output logic      sdr_cas_n,
   output logic      sdr_we_n,
   output logic      sdr_cke,
   output bank_t     sdr_ba,
   output sdr_addr_t sdr_addr,
   output sdr_mask_t sdr_dqm,
   input  sdr_data_t sdr_din,
   output sdr_data_t sdr_dout,
   output logic      sdr_den
);

   // ------------------------------
   // Internal links
   // ------------------------------
   logic      r2b_req, r2b_write, b2r_ack;
   bank_t     r2b_ba, b2x_ba;
   row_t      r2b_row;
   col_t      r2b_col;
   logic      b2x_req, x2b_ack, x2r_done;
   sdr_cmd_t  b2x_cmd;
   sdr_addr_t b2x_addr;
   logic      x2c_wr_hi, x2c_rd_lo, x2c_rd_hi;

   sdrc_req_gen i_req_gen (
      .clk, .rst, .app_req, .app_addr, .app_wr_n, .sdr_init_done,
      .b2r_ack, .x2r_done, .app_req_ack,
      .r2b_req, .r2b_ba, .r2b_row, .r2b_col, .r2b_write
   );

   sdrc_bank_ctl #(.TRCD(TRCD)) i_bank_ctl (
      .clk, .rst, .r2b_req, .r2b_ba, .r2b_row, .r2b_col, .r2b_write,
      .x2b_ack, .b2r_ack, .b2x_req, .b2x_cmd, .b2x_ba, .b2x_addr
   );

   sdrc_xfr_ctl #(
      .CAS_LAT(CAS_LAT), .TRP(TRP), .TRFC(TRFC), .TWR(TWR),
      .RFSH_INTERVAL(RFSH_INTERVAL), .INIT_WAIT(INIT_WAIT)
   ) i_xfr_ctl (
      .clk, .rst, .b2x_req, .b2x_cmd, .b2x_ba, .b2x_addr,
      .x2b_ack, .x2r_done, .sdr_init_done, .x2c_wr_hi, .x2c_rd_lo, .x2c_rd_hi,
      .sdr_cs_n, .sdr_ras_n, .sdr_cas_n, .sdr_we_n, .sdr_cke,
      .sdr_ba, .sdr_addr, .sdr_den
   );

   sdrc_bs_convert i_bs_convert (
      .clk, .rst, .app_wr_data, .app_be, .sdr_din,
      .x2c_wr_hi, .x2c_rd_lo, .x2c_rd_hi,
      .sdr_dout, .sdr_dqm, .app_rd_data
   );

endmodule

// File: src/sdrc_pkg.sv
package sdrc_pkg;

   // ------------------------------
   // Vector types
   // ------------------------------
   typedef logic [20:0] app_addr_t;   // {bank, row, column word}
   typedef logic [31:0] app_data_t;
   typedef logic [3:0]  app_be_t;     // Active high
   typedef logic [15:0] sdr_data_t;
   typedef logic [1:0]  sdr_mask_t;   // High masks the byte
   typedef logic [11:0] sdr_addr_t;
   typedef logic [1:0]  bank_t;
   typedef logic [11:0] row_t;
   typedef logic [7:0]  col_t;        // Column word plus a 0
   typedef logic [3:0]  sdr_cmd_t;    // {cs_n, ras_n, cas_n, we_n}

   // ------------------------------
   // SDRAM commands
   // ------------------------------
   localparam sdr_cmd_t CMD_NOP   = 4'b0111;
   localparam sdr_cmd_t CMD_ACT   = 4'b0011;
   localparam sdr_cmd_t CMD_READ  = 4'b0101;
   localparam sdr_cmd_t CMD_WRITE = 4'b0100;
   localparam sdr_cmd_t CMD_PRE   = 4'b0010;
   localparam sdr_cmd_t CMD_REF   = 4'b0001;
   localparam sdr_cmd_t CMD_MRS   = 4'b0000;
   localparam sdr_cmd_t CMD_DESEL = 4'b1111;  // cs_n high, rest don't care

   localparam int AP_BIT = 10;                 // Auto precharge, or precharge all
   localparam logic [3:0] BURST_CODE = 4'b0001; // Sequential, length 2

   // Application handshake states
   typedef enum logic [1:0] {
      REQ_IDLE, REQ_BUSY, REQ_ACK, REQ_RELEASE
   } req_state_t;

   // Command sequencer states
   typedef enum logic [3:0] {
      XFR_INIT_WAIT, XFR_INIT_PRE, XFR_INIT_REF, XFR_INIT_MRS,
      XFR_IDLE, XFR_REFRESH, XFR_RW, XFR_DATA, XFR_RECOVER
   } xfr_state_t;

endpackage

// File: src/sdrc_req_gen.sv
`timescale 1ns/100ps

module sdrc_req_gen import sdrc_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      app_req,
   input  app_addr_t app_addr,
   input  logic      app_wr_n,
   input  logic      sdr_init_done,
   input  logic      b2r_ack,
   input  logic      x2r_done,
   output logic      app_req_ack,
   output logic      r2b_req,
   output bank_t     r2b_ba,
   output row_t      r2b_row,
   output col_t      r2b_col,
   output logic      r2b_write
);

   req_state_t state;
   logic       accept;   // New request taken this cycle

   // Requests wait here until init is over
   assign accept = (state == REQ_IDLE) && app_req && sdr_init_done;

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= REQ_IDLE;
         app_req_ack <= 1'b0;
         r2b_req     <= 1'b0;
      end else begin
         case (state)
            REQ_IDLE: begin
               if (accept) begin
                  r2b_req <= 1'b1;        // Out one cycle after sampling
                  state   <= REQ_BUSY;
               end
            end
            REQ_BUSY: begin
               if (b2r_ack) begin
                  r2b_req <= 1'b0;        // Command taken by the sequencer
               end
               if (x2r_done) begin
                  app_req_ack <= 1'b1;
                  state       <= REQ_ACK;
               end
            end
            REQ_ACK: begin
               if (!app_req) begin
                  app_req_ack <= 1'b0;    // Fourth phase
                  state       <= REQ_RELEASE;
               end
            end
            default: state <= REQ_IDLE;   // REQ_RELEASE, one dead cycle
         endcase
      end
   end

   // Address split: bank, row, column word
   always_ff @(posedge clk) begin
      if (accept) begin
         r2b_ba    <= app_addr[20:19];
         r2b_row   <= app_addr[18:7];
         r2b_col   <= {app_addr[6:0], 1'b0};  // Even column, BL2
         r2b_write <= ~app_wr_n;
      end
   end

endmodule

// File: src/sdrc_xfr_ctl.sv
`timescale 1ns/100ps

module sdrc_xfr_ctl import sdrc_pkg::*; #(
   parameter int CAS_LAT       = 2,
   parameter int TRP           = 2,
   parameter int TRFC          = 6,
   parameter int TWR           = 2,
   parameter int RFSH_INTERVAL = 1560,
   parameter int INIT_WAIT     = 20000
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      b2x_req,
   input  sdr_cmd_t  b2x_cmd,
   input  bank_t     b2x_ba,
   input  sdr_addr_t b2x_addr,
   output logic      x2b_ack,
   output logic      x2r_done,
   output logic      sdr_init_done,
   output logic      x2c_wr_hi,
   output logic      x2c_rd_lo,
   output logic      x2c_rd_hi,
   output logic      sdr_cs_n,
   output logic      sdr_ras_n,
   output logic      sdr_cas_n,
   output logic      sdr_we_n,
   output logic      sdr_cke,
   output bank_t     sdr_ba,
   output sdr_addr_t sdr_addr,
   output logic      sdr_den
);

   localparam int DLY_W = $clog2(INIT_WAIT + TRFC + TWR + TRP + CAS_LAT + 3);
   localparam int RF_W  = $clog2(RFSH_INTERVAL);
   localparam sdr_addr_t PRE_ALL  = sdr_addr_t'(1 << AP_BIT);
   localparam sdr_addr_t MODE_REG = {5'b0, 3'(CAS_LAT), BURST_CODE};

   xfr_state_t       state;
   sdr_cmd_t         cmd_q;      // Registered command pins
   logic [DLY_W-1:0] dly;        // Shared wait counter
   logic [RF_W-1:0]  rfsh_cnt;
   logic             rfsh_pend;
   logic             ref_two;    // First init REF done
   logic             wr_q;       // Current access is a write
   logic             b2x_take;
   logic             issue_pre;
   logic             issue_mrs;

   assign {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n} = cmd_q;
   assign sdr_cke = 1'b1;         // No power down

   // Refresh beats a new ACT, never an open bank
   assign b2x_take  = b2x_req && !x2b_ack &&
                      ((state == XFR_RW) || (state == XFR_IDLE && !rfsh_pend));
   assign issue_pre = (state == XFR_INIT_WAIT) && (dly == '0);
   assign issue_mrs = (state == XFR_INIT_REF) && (dly == '0) && ref_two;

   always_ff @(posedge clk) begin
      if (rst) begin
         state         <= XFR_INIT_WAIT;
         dly           <= DLY_W'(INIT_WAIT - 1);
         cmd_q         <= CMD_NOP;
         rfsh_cnt      <= '0;
         rfsh_pend     <= 1'b0;
         ref_two       <= 1'b0;
         wr_q          <= 1'b0;
         sdr_init_done <= 1'b0;
         sdr_den       <= 1'b0;
         x2b_ack       <= 1'b0;
         x2r_done      <= 1'b0;
         x2c_wr_hi     <= 1'b0;
         x2c_rd_lo     <= 1'b0;
         x2c_rd_hi     <= 1'b0;
      end else begin
         // Single cycle strobes
         cmd_q     <= CMD_NOP;
         sdr_den   <= 1'b0;
         x2b_ack   <= 1'b0;
         x2r_done  <= 1'b0;
         x2c_wr_hi <= 1'b0;
         x2c_rd_lo <= 1'b0;
         x2c_rd_hi <= 1'b0;

         // ------------------------------
         // Refresh interval timer
         // ------------------------------
         if (!sdr_init_done || rfsh_cnt == RF_W'(RFSH_INTERVAL - 1)) begin
            rfsh_cnt <= '0;
         end else begin
            rfsh_cnt <= rfsh_cnt + 1'b1;
         end
         if (rfsh_cnt == RF_W'(RFSH_INTERVAL - 1)) begin
            rfsh_pend <= 1'b1;
         end

         if (b2x_take) begin
            cmd_q   <= b2x_cmd;   // Ack lines up with the pins
            x2b_ack <= 1'b1;
         end

         case (state)
            XFR_INIT_WAIT: begin
               dly <= dly - 1'b1;
               if (issue_pre) begin
                  cmd_q <= CMD_PRE;
                  dly   <= DLY_W'(TRP - 1);
                  state <= XFR_INIT_PRE;
               end
            end
            XFR_INIT_PRE: begin
               dly <= dly - 1'b1;
               if (dly == '0) begin
                  cmd_q <= CMD_REF;
                  dly   <= DLY_W'(TRFC - 1);
                  state <= XFR_INIT_REF;
               end
            end
            XFR_INIT_REF: begin
               dly <= dly - 1'b1;
               if (issue_mrs) begin
                  cmd_q <= CMD_MRS;
                  dly   <= DLY_W'(1);   // tMRD
                  state <= XFR_INIT_MRS;
               end else if (dly == '0) begin
                  ref_two <= 1'b1;
                  cmd_q   <= CMD_REF;
                  dly     <= DLY_W'(TRFC - 1);
               end
            end
            XFR_INIT_MRS: begin
               dly <= dly - 1'b1;
               if (dly == '0) begin
                  sdr_init_done <= 1'b1;
                  state         <= XFR_IDLE;
               end
            end
            XFR_IDLE: begin
               if (rfsh_pend) begin
                  cmd_q     <= CMD_REF;
                  rfsh_pend <= 1'b0;
                  dly       <= DLY_W'(TRFC - 1);
                  state     <= XFR_REFRESH;
               end else if (b2x_take) begin
                  state <= XFR_RW;        // ACT out, wait for column cmd
               end
            end
            XFR_RW: begin
               if (b2x_take) begin
                  wr_q    <= (b2x_cmd == CMD_WRITE);
                  sdr_den <= (b2x_cmd == CMD_WRITE);  // Low beat with WRITE
                  dly     <= '0;
                  state   <= XFR_DATA;
               end
            end
            XFR_DATA: begin
               dly <= dly + 1'b1;
               if (wr_q) begin
                  sdr_den   <= 1'b1;      // High beat
                  x2c_wr_hi <= 1'b1;
                  x2r_done  <= 1'b1;
                  dly       <= DLY_W'(TWR + TRP - 1);
                  state     <= XFR_RECOVER;
               end else begin
                  // Beats registered once in the converter
                  x2c_rd_lo <= (dly == DLY_W'(CAS_LAT));
                  x2c_rd_hi <= (dly == DLY_W'(CAS_LAT + 1));
                  if (dly == DLY_W'(CAS_LAT + 2)) begin
                     x2r_done <= 1'b1;
                     dly      <= DLY_W'(TRP - 1);
                     state    <= XFR_RECOVER;
                  end
               end
            end
            XFR_REFRESH, XFR_RECOVER: begin
               dly <= dly - 1'b1;
               if (dly == '0) begin
                  state <= XFR_IDLE;
               end
            end
            default: state <= XFR_IDLE;
         endcase
      end
   end

   // Bank and address pins
   always_ff @(posedge clk) begin
      if (b2x_take) begin
         sdr_ba   <= b2x_ba;
         sdr_addr <= b2x_addr;
      end else if (issue_pre) begin
         sdr_addr <= PRE_ALL;
      end else if (issue_mrs) begin
         sdr_ba   <= '0;
         sdr_addr <= MODE_REG;
      end
   end

endmodule

// File: verification/sdram_model.sv
`timescale 1ns/100ps

module sdram_model import sdrc_pkg::*; #(
   parameter int CAS_LAT = 2,
   parameter int TRCD    = 2,
   parameter int TRP     = 2,
   parameter int TRFC    = 6,
   parameter int TWR     = 2
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      cs_n,
   input  logic      ras_n,
   input  logic      cas_n,
   input  logic      we_n,
   input  bank_t     ba,
   input  sdr_addr_t addr,
   input  sdr_mask_t dqm,
   input  sdr_data_t dq_in,
   input  logic      den,
   output sdr_data_t dq_out,
   output logic      protocol_err
);

   sdr_data_t mem [int];      // Sparse storage, key {bank, row, column}
   logic      open [4];
   row_t      open_row [4];
   int        act_cyc [4];
   int        pre_cyc [4];    // Precharge start per bank
   int        ref_cyc;
   int        cyc;
   logic      wr_pend;        // High write beat due next edge
   int        wr_key;
   logic      rd_pend;
   int        rd_cyc;
   int        rd_key;
   logic      err;            // Sticky

   task automatic report_violation(input string what);
      $display("SDRAM model at %0t ns: %s", $time, what);
      err = 1'b1;
   endtask

   function automatic sdr_data_t peek(input int key);
      if (mem.exists(key)) begin
         return mem[key];
      end
      return '0;
   endfunction

   // One write beat, dqm high keeps the old byte
   task automatic store(input int key);
      sdr_data_t word;
      if (!den)
         report_violation("write beat without sdr_den");
      word = peek(key);
      if (!dqm[0]) word[7:0] = dq_in[7:0];
      if (!dqm[1]) word[15:8] = dq_in[15:8];
      mem[key] = word;
   endtask

   always @(posedge clk) begin
      sdr_cmd_t cmd;
      int       key;
      cmd = {cs_n, ras_n, cas_n, we_n};
      if (rst) begin
         cyc     = 0;
         ref_cyc = -1000;
         wr_pend = 1'b0;
         rd_pend = 1'b0;
         err     = 1'b0;
         for (int b = 0; b < 4; b++) begin
            open[b]    = 1'b0;
            act_cyc[b] = -1000;
            pre_cyc[b] = -1000;
         end
         dq_out       <= '0;
         protocol_err <= 1'b0;
      end else begin
         cyc = cyc + 1;
         if (wr_pend) begin
            store(wr_key);
            wr_pend = 1'b0;
         end

         // ------------------------------
         // Command decode
         // ------------------------------
         case (cmd)
            CMD_ACT: begin
               if (open[ba])
                  report_violation("ACT to a bank that is already open");
               if (cyc - pre_cyc[ba] < TRP)
                  report_violation("ACT within tRP of the precharge");
               if (cyc - ref_cyc < TRFC)
                  report_violation("ACT within tRFC of a REF");
               open[ba]     = 1'b1;
               open_row[ba] = addr;
               act_cyc[ba]  = cyc;
            end
            CMD_READ, CMD_WRITE: begin
               if (!open[ba])
                  report_violation("READ or WRITE to a closed bank");
               if (cyc - act_cyc[ba] < TRCD)
                  report_violation("READ or WRITE within tRCD of ACT");
               if (!addr[AP_BIT])
                  report_violation("READ or WRITE without auto precharge");
               open[ba] = 1'b0;   // Auto precharge closes it
               key = {ba, open_row[ba], addr[7:0]};
               if (cmd == CMD_WRITE) begin
                  store(key);                     // Low beat with the command
                  wr_pend     = 1'b1;
                  wr_key      = key + 1;
                  pre_cyc[ba] = cyc + 1 + TWR;    // tWR after the high beat
               end else begin
                  rd_pend     = 1'b1;
                  rd_cyc      = cyc;
                  rd_key      = key;
                  pre_cyc[ba] = cyc + CAS_LAT + 1;
               end
            end
            CMD_REF: begin
               for (int b = 0; b < 4; b++) begin
                  if (open[b])
                     report_violation("REF while a bank is open");
                  if (cyc - pre_cyc[b] < TRP)
                     report_violation("REF within tRP of a precharge");
               end
               if (cyc - ref_cyc < TRFC)
                  report_violation("REF within tRFC of the previous REF");
               ref_cyc = cyc;
            end
            CMD_PRE: begin
               for (int b = 0; b < 4; b++) begin
                  if (addr[AP_BIT] || ba == bank_t'(b)) begin
                     open[b]    = 1'b0;
                     pre_cyc[b] = cyc;
                  end
               end
            end
            CMD_MRS: begin
               for (int b = 0; b < 4; b++) begin
                  if (open[b])
                     report_violation("MRS while a bank is open");
               end
            end
            default: ;   // NOP or deselect
         endcase

         // Read beats, sampled by the controller CAS_LAT edges after READ
         if (rd_pend && cyc == rd_cyc + CAS_LAT - 1) begin
            dq_out <= peek(rd_key);
         end
         if (rd_pend && cyc == rd_cyc + CAS_LAT) begin
            dq_out  <= peek(rd_key + 1);
            rd_pend = 1'b0;
         end
         protocol_err <= err;
      end
   end

endmodule

// File: verification/tb_sdrc_core.sv
`timescale 1ns/100ps

module tb_sdrc_core import sdrc_pkg::*; ();

   localparam int CAS_LAT       = 2;
   localparam int TRCD          = 2;
   localparam int TRP           = 2;
   localparam int TRFC          = 6;
   localparam int TWR           = 2;
   localparam int RFSH_INTERVAL = 200;
   localparam int INIT_WAIT     = 20;
   localparam int POOL_SIZE     = 12;
   localparam int INIT_TIMEOUT  = 1000;
   localparam int ACK_TIMEOUT   = 100;
   // Mode register with CAS latency in bits 6:4 and sequential BL2 below
   localparam sdr_addr_t MRS_EXP = sdr_addr_t'((CAS_LAT << 4) | BURST_CODE);

   logic      clk;
   logic      rst;
   logic      app_req;
   app_addr_t app_addr;
   logic      app_wr_n;
   app_data_t app_wr_data;
   app_be_t   app_be;
   logic      app_req_ack;
   app_data_t app_rd_data;
   logic      sdr_init_done;
   logic      sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n, sdr_cke, sdr_den;
   bank_t     sdr_ba;
   sdr_addr_t sdr_addr;
   sdr_mask_t sdr_dqm;
   sdr_data_t sdr_din, sdr_dout;
   logic      model_err;

   app_data_t ref_mem [app_addr_t];   // Expected contents per word address
   app_addr_t pool [POOL_SIZE];
   int        cyc = 0;
   int        init_step = 0;          // PRE, REF, REF, MRS seen so far
   logic      init_seen = 1'b0;
   int        last_ref = 0;
   logic      ack_q = 1'b0;

   sdrc_core #(
      .CAS_LAT(CAS_LAT), .TRCD(TRCD), .TRP(TRP), .TRFC(TRFC), .TWR(TWR),
      .RFSH_INTERVAL(RFSH_INTERVAL), .INIT_WAIT(INIT_WAIT)
   ) i_sdrc_core (
      .clk, .rst, .app_req, .app_addr, .app_wr_n, .app_wr_data, .app_be,
      .app_req_ack, .app_rd_data, .sdr_init_done,
      .sdr_cs_n, .sdr_ras_n, .sdr_cas_n, .sdr_we_n, .sdr_cke,
      .sdr_ba, .sdr_addr, .sdr_dqm, .sdr_din, .sdr_dout, .sdr_den
   );

   sdram_model #(
      .CAS_LAT(CAS_LAT), .TRCD(TRCD), .TRP(TRP), .TRFC(TRFC), .TWR(TWR)
   ) i_sdram_model (
      .clk, .rst, .cs_n(sdr_cs_n), .ras_n(sdr_ras_n), .cas_n(sdr_cas_n),
      .we_n(sdr_we_n), .ba(sdr_ba), .addr(sdr_addr), .dqm(sdr_dqm),
      .dq_in(sdr_dout), .den(sdr_den), .dq_out(sdr_din), .protocol_err(model_err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic report_fail(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic compare(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      if (actual !== expected) begin
         report_fail($sformatf("Fail at %0.1f ns: %s is %h, expected %h",
                               $realtime, name, actual, expected));
      end
   endtask

   function automatic app_data_t merge_bytes(input app_data_t old, input app_data_t data,
                                             input app_be_t be);
      app_data_t word;
      word = old;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) word[8*i +: 8] = data[8*i +: 8];
      end
      return word;
   endfunction

   // One four-phase transfer started on a rising edge
   task automatic access(input logic wr, input app_addr_t addr, input app_data_t wdata,
                         input app_be_t be, output app_data_t rdata);
      int n;
      app_req     <= 1'b1;
      app_addr    <= addr;
      app_wr_n    <= !wr;
      app_wr_data <= wdata;
      app_be      <= be;
      n = 0;
      do begin
         @(posedge clk);
         n = n + 1;
         if (n > ACK_TIMEOUT) report_fail("Timeout waiting for app_req_ack to rise");
      end while (!app_req_ack);
      rdata = app_rd_data;   // Valid while ack is high
      app_req <= 1'b0;
      n = 0;
      do begin
         @(posedge clk);
         n = n + 1;
         if (n > ACK_TIMEOUT) report_fail("app_req_ack stayed high after app_req fell");
      end while (app_req_ack);
   endtask

   // ------------------------------
   // Pin and handshake monitor
   // ------------------------------
   always @(posedge clk) begin
      sdr_cmd_t cmd;
      cmd = {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n};
      cyc = cyc + 1;
      if (model_err) report_fail("SDRAM model found a protocol violation");
      if (!rst && !sdr_init_done) begin
         case (cmd)
            CMD_PRE: begin
               compare("init step at PRE", init_step, 0);
               compare("sdr_addr[10] at PRE", sdr_addr[AP_BIT], 1);
               init_step = 1;
            end
            CMD_REF: begin
               if (init_step == 2)
                  compare("REF spacing at least tRFC", (cyc - last_ref) >= TRFC, 1);
               else
                  compare("init step at first REF", init_step, 1);
               last_ref  = cyc;
               init_step = init_step + 1;
            end
            CMD_MRS: begin
               compare("init step at MRS", init_step, 3);
               compare("sdr_addr at MRS", sdr_addr, MRS_EXP);
               init_step = 4;
            end
            CMD_ACT, CMD_READ, CMD_WRITE: report_fail("Access command before sdr_init_done");
            default: ;
         endcase
      end else if (!rst) begin
         if (!init_seen) begin
            compare("init step at sdr_init_done", init_step, 4);   // Only after MRS
            init_seen = 1'b1;
            last_ref  = cyc;
         end
         if (cmd == CMD_REF) begin
            last_ref = cyc;
         end else if (cyc - last_ref > RFSH_INTERVAL + 20) begin
            report_fail("Refresh interval exceeded");
         end
         if (cmd == CMD_ACT) begin
            compare("sdr_ba at ACT", sdr_ba, app_addr[20:19]);
            compare("sdr_addr (row)", sdr_addr, app_addr[18:7]);
         end
         if (cmd == CMD_READ || cmd == CMD_WRITE) begin
            compare("sdr_ba at READ/WRITE", sdr_ba, app_addr[20:19]);
            compare("sdr_addr (column)", sdr_addr[7:0], {app_addr[6:0], 1'b0});
            compare("sdr_addr[10] at READ/WRITE", sdr_addr[AP_BIT], 1);
            compare("sdr_we_n", sdr_we_n, app_wr_n);
         end
         if (app_req_ack && !ack_q && !app_req)
            report_fail("app_req_ack rose while app_req was low");
         ack_q = app_req_ack;
      end
   end

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin
      app_data_t rd_word;
      app_data_t wr_word;
      app_addr_t addr;
      app_be_t   be;
      logic      wr;
      int        n;
      void'($urandom(23084));
      rst         = 1'b1;
      app_req     = 1'b0;
      app_addr    = '0;
      app_wr_n    = 1'b1;
      app_wr_data = '0;
      app_be      = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      compare("app_req_ack after reset", app_req_ack, 0);
      compare("sdr_init_done after reset", sdr_init_done, 0);
      compare("command after reset", {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n}, CMD_NOP);
      compare("sdr_cke after reset", sdr_cke, 1);
      compare("sdr_den after reset", sdr_den, 0);

      n = 0;
      while (!sdr_init_done) begin
         if (n == INIT_TIMEOUT) report_fail("Timeout waiting for sdr_init_done");
         @(posedge clk);
         n = n + 1;
      end

      // Full word write and read back
      addr    = app_addr_t'($urandom);
      wr_word = $urandom;
      access(1'b1, addr, wr_word, 4'hf, rd_word);
      access(1'b0, addr, '0, 4'hf, rd_word);
      compare("app_rd_data", rd_word, wr_word);

      // Known contents for every pool address
      for (int i = 0; i < POOL_SIZE; i++) begin
         pool[i]          = app_addr_t'($urandom);
         ref_mem[pool[i]] = $urandom;
         access(1'b1, pool[i], ref_mem[pool[i]], 4'hf, rd_word);
      end

      for (int i = 0; i < 300; i++) begin
         addr    = pool[$urandom % POOL_SIZE];
         wr      = 1'($urandom);
         wr_word = $urandom;
         be      = app_be_t'($urandom);
         access(wr, addr, wr_word, be, rd_word);
         if (wr)
            ref_mem[addr] = merge_bytes(ref_mem[addr], wr_word, be);
         else
            compare("app_rd_data", rd_word, ref_mem[addr]);
      end

      $display("No errors");
      $finish;
   end

endmodule
